// ==== src/cpu_pkg.sv ====
package cpu_pkg;

    // datapath widths
    localparam int XLEN     = 64;
    localparam int ILEN     = 32;
    localparam int NUM_REGS = 32;
    localparam int REG_AW   = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [ILEN-1:0]   instr_t;
    typedef logic [REG_AW-1:0] reg_idx_t;

    // X31 is hardwired to zero
    localparam reg_idx_t ZERO_REG = 5'd31;

    // fetch advances one 32-bit word per cycle
    localparam word_t INSTR_BYTES = 64'd4;

    // opcode patterns, matched against the top bits of the instruction
    localparam logic [9:0]  OP_ADDI = 10'b1001000100;
    localparam logic [10:0] OP_ADDS = 11'b10101011000;
    localparam logic [10:0] OP_SUBS = 11'b11101011000;
    localparam logic [10:0] OP_AND  = 11'b10001010000;
    localparam logic [10:0] OP_EOR  = 11'b11001010000;
    localparam logic [10:0] OP_LSR  = 11'b11010011010;
    localparam logic [10:0] OP_LDUR = 11'b11111000010;
    localparam logic [10:0] OP_STUR = 11'b11111000000;
    localparam logic [5:0]  OP_B    = 6'b000101;
    localparam logic [7:0]  OP_CBZ  = 8'b10110100;
    localparam logic [7:0]  OP_BLT  = 8'b01010100;

    // ALU operations
    typedef enum logic [2:0] {
        ALU_LSR = 3'b001,
        ALU_ADD = 3'b010,
        ALU_SUB = 3'b011,
        ALU_AND = 3'b100,
        ALU_EOR = 3'b110
    } alu_op_e;

    // immediate formats for the ALU B input
    localparam logic [1:0] IMM_ADDI = 2'd0;
    localparam logic [1:0] IMM_LDST = 2'd1;
    localparam logic [1:0] IMM_LSR  = 2'd2;

endpackage

// ==== src/decoder.sv ====
`timescale 1ns/100ps

module decoder (
    input  cpu_pkg::instr_t  instr,
    output logic             reg2loc,
    output logic             alu_src,
    output logic             mem_to_reg,
    output logic             reg_write,
    output logic             mem_write,
    output logic             uncond_br,
    output logic             cbz_br,
    output logic             blt_br,
    output logic             set_flags,
    output cpu_pkg::alu_op_e alu_op,
    output logic [1:0]       imm_kind
);
    import cpu_pkg::*;

    logic [10:0] op11;

    assign op11 = instr[31:21];

    // one priority chain drives every control, unmatched words fall through as a no-op
    always_comb begin
        reg2loc    = 1'b0;
        alu_src    = 1'b0;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        mem_write  = 1'b0;
        uncond_br  = 1'b0;
        cbz_br     = 1'b0;
        blt_br     = 1'b0;
        set_flags  = 1'b0;
        alu_op     = ALU_ADD;
        imm_kind   = IMM_ADDI;

        if (instr[31:22] == OP_ADDI) begin
            alu_src   = 1'b1;
            reg_write = 1'b1;
        end else if (op11 == OP_ADDS) begin
            reg2loc   = 1'b1;
            reg_write = 1'b1;
            set_flags = 1'b1;
        end else if (op11 == OP_AND) begin
            reg2loc   = 1'b1;
            reg_write = 1'b1;
            alu_op    = ALU_AND;
        end else if (op11 == OP_SUBS) begin
            reg2loc   = 1'b1;
            reg_write = 1'b1;
            set_flags = 1'b1;
            alu_op    = ALU_SUB;
        end else if (op11 == OP_LDUR) begin
            alu_src    = 1'b1;
            mem_to_reg = 1'b1;
            reg_write  = 1'b1;
            imm_kind   = IMM_LDST;
        end else if (op11 == OP_STUR) begin
            // Rt goes out as store data through the second read port
            alu_src   = 1'b1;
            mem_write = 1'b1;
            imm_kind  = IMM_LDST;
        end else if (instr[31:26] == OP_B) begin
            uncond_br = 1'b1;
        end else if (instr[31:24] == OP_CBZ) begin
            cbz_br = 1'b1;
        end else if (op11 == OP_LSR) begin
            alu_src   = 1'b1;
            reg_write = 1'b1;
            alu_op    = ALU_LSR;
            imm_kind  = IMM_LSR;
        end else if (op11 == OP_EOR) begin
            reg2loc   = 1'b1;
            reg_write = 1'b1;
            alu_op    = ALU_EOR;
        end else if (instr[31:24] == OP_BLT) begin
            blt_br = 1'b1;
        end
    end

endmodule

// ==== src/imm_gen.sv ====
`timescale 1ns/100ps

module imm_gen (
    input  cpu_pkg::instr_t instr,
    input  logic [1:0]      imm_kind,
    output cpu_pkg::word_t  imm
);
    import cpu_pkg::*;

    logic [11:0] imm12;
    logic [8:0]  imm9;
    logic [5:0]  shamt;

    assign imm12 = instr[21:10];
    assign imm9  = instr[20:12];
    assign shamt = instr[15:10];

    always_comb begin
        case (imm_kind)
            // load/store offset is signed
            IMM_LDST: imm = {{(XLEN-9){imm9[8]}}, imm9};
            IMM_LSR:  imm = {{(XLEN-6){1'b0}}, shamt};
            default:  imm = {{(XLEN-12){1'b0}}, imm12};
        endcase
    end

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/100ps

module regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t rd_addr1,
    input  cpu_pkg::reg_idx_t rd_addr2,
    input  cpu_pkg::reg_idx_t wr_addr,
    input  logic              wr_en,
    input  cpu_pkg::word_t    wr_data,
    output cpu_pkg::word_t    rd1,
    output cpu_pkg::word_t    rd2
);
    import cpu_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != ZERO_REG)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // X31 always reads as zero
    assign rd1 = (rd_addr1 == ZERO_REG) ? '0 : regs[rd_addr1];
    assign rd2 = (rd_addr2 == ZERO_REG) ? '0 : regs[rd_addr2];

endmodule

// ==== src/alu.sv ====
`timescale 1ns/100ps

module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_op_e op,
    output cpu_pkg::word_t   result,
    output logic             neg,
    output logic             ovf
);
    import cpu_pkg::*;

    word_t sum;
    word_t diff;
    logic  add_ovf;
    logic  sub_ovf;

    assign sum  = a + b;
    assign diff = a - b;

    // signed overflow: operands agree in sign (add) or differ (sub) and the result flips
    assign add_ovf = (a[XLEN-1] == b[XLEN-1]) && (sum[XLEN-1] != a[XLEN-1]);
    assign sub_ovf = (a[XLEN-1] != b[XLEN-1]) && (diff[XLEN-1] != a[XLEN-1]);

    always_comb begin
        result = sum;
        ovf    = 1'b0;
        case (op)
            ALU_ADD: begin
                result = sum;
                ovf    = add_ovf;
            end
            ALU_SUB: begin
                result = diff;
                ovf    = sub_ovf;
            end
            ALU_AND: result = a & b;
            ALU_EOR: result = a ^ b;
            // shift amount is the low six bits only
            ALU_LSR: result = a >> b[5:0];
            default: result = sum;
        endcase
    end

    assign neg = result[XLEN-1];

endmodule

// ==== src/pc_branch.sv ====
`timescale 1ns/100ps

module pc_branch (
    input  logic            clk,
    input  logic            rst_n,
    input  cpu_pkg::instr_t instr,
    input  logic            uncond_br,
    input  logic            cbz_br,
    input  logic            blt_br,
    input  logic            set_flags,
    input  logic            alu_neg,
    input  logic            alu_ovf,
    input  cpu_pkg::word_t  rt_val,
    output cpu_pkg::word_t  pc
);
    import cpu_pkg::*;

    logic  flag_n;
    logic  flag_v;
    word_t br_offset;
    word_t br_target;
    word_t pc_next;
    logic  take_br;

    // B uses imm26, CBZ and B.LT share imm19, both word offsets
    always_comb begin
        if (uncond_br) begin
            br_offset = {{(XLEN-28){instr[25]}}, instr[25:0], 2'b00};
        end else begin
            br_offset = {{(XLEN-21){instr[23]}}, instr[23:5], 2'b00};
        end
    end

    assign br_target = pc + br_offset;

    // B.LT reads the flags left by the last ADDS or SUBS
    assign take_br = uncond_br
                   | (cbz_br & (rt_val == '0))
                   | (blt_br & (flag_n != flag_v));

    assign pc_next = take_br ? br_target : pc + INSTR_BYTES;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= '0;
            flag_n <= 1'b0;
            flag_v <= 1'b0;
        end else begin
            pc <= pc_next;
            if (set_flags) begin
                flag_n <= alu_neg;
                flag_v <= alu_ovf;
            end
        end
    end

endmodule

// ==== src/cpu_top.sv ====
`timescale 1ns/100ps

module cpu_top (
    input  logic              clk,
    input  logic              rst_n,
    // instruction fetch
    output cpu_pkg::word_t    imem_addr,
    input  cpu_pkg::instr_t   imem_data,
    // data memory, combinational read
    output cpu_pkg::word_t    dmem_addr,
    output cpu_pkg::word_t    dmem_wdata,
    output logic              dmem_we,
    output logic              dmem_re,
    input  cpu_pkg::word_t    dmem_rdata,
    // register write-back
    output logic              wb_en,
    output cpu_pkg::reg_idx_t wb_addr,
    output cpu_pkg::word_t    wb_data
);
    import cpu_pkg::*;

    logic     reg2loc, alu_src, mem_to_reg, reg_write, mem_write;
    logic     uncond_br, cbz_br, blt_br, set_flags;
    alu_op_e  alu_op;
    logic [1:0] imm_kind;
    word_t    imm;
    word_t    rd1, rd2;
    word_t    alu_b;
    word_t    result;
    logic     neg, ovf;
    word_t    pc;
    reg_idx_t rd2_addr;

    decoder u_decoder (
        .instr(imem_data), .reg2loc(reg2loc), .alu_src(alu_src),
        .mem_to_reg(mem_to_reg), .reg_write(reg_write), .mem_write(mem_write),
        .uncond_br(uncond_br), .cbz_br(cbz_br), .blt_br(blt_br),
        .set_flags(set_flags), .alu_op(alu_op), .imm_kind(imm_kind)
    );

    imm_gen u_imm_gen (.instr(imem_data), .imm_kind(imm_kind), .imm(imm));

    // second read port picks Rm for register ops, Rt for loads, stores and CBZ
    assign rd2_addr = reg2loc ? imem_data[20:16] : imem_data[4:0];

    regfile u_regfile (
        .clk(clk), .rst_n(rst_n),
        .rd_addr1(imem_data[9:5]), .rd_addr2(rd2_addr), .wr_addr(wb_addr),
        .wr_en(wb_en), .wr_data(wb_data), .rd1(rd1), .rd2(rd2)
    );

    assign alu_b = alu_src ? imm : rd2;

    alu u_alu (.a(rd1), .b(alu_b), .op(alu_op), .result(result), .neg(neg), .ovf(ovf));

    pc_branch u_pc_branch (
        .clk(clk), .rst_n(rst_n), .instr(imem_data),
        .uncond_br(uncond_br), .cbz_br(cbz_br), .blt_br(blt_br),
        .set_flags(set_flags), .alu_neg(neg), .alu_ovf(ovf),
        .rt_val(rd2), .pc(pc)
    );

    assign imem_addr  = pc;
    assign dmem_addr  = result;
    assign dmem_wdata = rd2;
    assign dmem_we    = mem_write;
    // only loads read memory
    assign dmem_re    = mem_to_reg;

    assign wb_en   = reg_write;
    assign wb_addr = imem_data[4:0];
    assign wb_data = mem_to_reg ? dmem_rdata : result;

endmodule

// ==== sim/tb_clk.sv ====
`timescale 1ns/100ps

module tb_clk (
    output logic clk,
    output logic rst_n
);
    localparam int PERIOD       = 10;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release lands 1 ns after the last reset edge, like the rest of the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// ==== sim/cpu_sva.sv ====
`timescale 1ns/100ps

module cpu_sva (
    input logic           clk,
    input logic           rst_n,
    input cpu_pkg::word_t imem_addr,
    input logic           dmem_we,
    input logic           dmem_re,
    input logic           wb_en
);

    // a load and a store never share a cycle
    a_no_rw_overlap: assert property (@(posedge clk) !(dmem_we && dmem_re))
        else $error("dmem_we and dmem_re are high in the same cycle");

    // fetch stays on word boundaries
    a_fetch_aligned: assert property (@(posedge clk) imem_addr[1:0] == 2'b00)
        else $error("imem_addr is not 4-byte aligned");

    a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !(wb_en || dmem_we || dmem_re))
        else $error("write-back or memory strobe active during reset");

endmodule

bind cpu_top cpu_sva u_sva (
    .clk(clk),
    .rst_n(rst_n),
    .imem_addr(imem_addr),
    .dmem_we(dmem_we),
    .dmem_re(dmem_re),
    .wb_en(wb_en)
);

// ==== sim/tb_cpu.sv ====
`timescale 1ns/100ps

module tb_cpu;
    import cpu_pkg::*;

    localparam int    PROG_LEN     = 256;
    localparam int    RESET_CYCLES = 3;
    // one instruction per cycle at most, plus reset and some slack
    localparam int    MAX_CYCLES   = PROG_LEN + RESET_CYCLES + 41;
    localparam word_t PROG_END     = word_t'(PROG_LEN) << 2;

    typedef enum int {
        K_ADDI, K_ADDS, K_SUBS, K_AND, K_EOR, K_LSR,
        K_LDUR, K_STUR, K_B, K_CBZ, K_BLT, K_NOP
    } kind_e;

    logic     clk;
    logic     rst_n;
    word_t    imem_addr;
    instr_t   imem_data;
    word_t    dmem_addr;
    word_t    dmem_wdata;
    logic     dmem_we;
    logic     dmem_re;
    word_t    dmem_rdata;
    logic     wb_en;
    reg_idx_t wb_addr;
    word_t    wb_data;

    instr_t      prog [PROG_LEN];
    kind_e       kinds [PROG_LEN];
    word_t       dmem [word_t];
    word_t       model_regs [NUM_REGS];
    logic        model_n;
    logic        model_v;
    word_t       model_pc;
    logic [63:0] rng;
    logic        pending_we;
    word_t       pending_addr;
    word_t       pending_data;
    int          cycles = 0;

    tb_clk u_clk (.clk(clk), .rst_n(rst_n));

    cpu_top dut (
        .clk(clk), .rst_n(rst_n),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_we(dmem_we), .dmem_re(dmem_re), .dmem_rdata(dmem_rdata),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
    );

    function automatic logic [63:0] xorshift(input logic [63:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 7);
        s = s ^ (s << 17);
        return s;
    endfunction

    function automatic int rand_below(input int n);
        rng = xorshift(rng);
        return int'(rng[15:0]) % n;
    endfunction

    // unwritten addresses read a pattern that every address bit reaches
    function automatic word_t fill_value(input word_t addr);
        return (addr * 64'h9E37_79B9_7F4A_7C15) ^ (addr >> 29) ^ 64'h0F0F_3C3C_5A5A_9696;
    endfunction

    function automatic word_t mem_read(input word_t addr);
        word_t val;
        val = dmem.exists(addr) ? dmem[addr] : fill_value(addr);
        return val;
    endfunction

    function automatic word_t reg_val(input reg_idx_t idx);
        return (idx == ZERO_REG) ? '0 : model_regs[idx];
    endfunction

    function automatic instr_t make_instr(input kind_e k);
        logic [4:0]  rd;
        logic [4:0]  rn;
        logic [4:0]  rm;
        logic [11:0] imm12;
        logic [8:0]  imm9;
        logic [5:0]  shamt;
        logic [25:0] jump;
        instr_t      w;
        rd    = 5'(rand_below(32));
        rn    = 5'(rand_below(32));
        rm    = 5'(rand_below(32));
        imm12 = 12'(rand_below(4096));
        imm9  = 9'(rand_below(512));
        shamt = 6'(rand_below(64));
        // forward jumps of 1 to 4 instructions only
        jump  = 26'(rand_below(4) + 1);
        case (k)
            K_ADDI: w = {OP_ADDI, imm12, rn, rd};
            K_ADDS: w = {OP_ADDS, rm, 6'd0, rn, rd};
            K_SUBS: w = {OP_SUBS, rm, 6'd0, rn, rd};
            K_AND:  w = {OP_AND, rm, 6'd0, rn, rd};
            K_EOR:  w = {OP_EOR, rm, 6'd0, rn, rd};
            K_LSR:  w = {OP_LSR, 5'd0, shamt, rn, rd};
            K_LDUR: w = {OP_LDUR, imm9, 2'b00, rn, rd};
            K_STUR: w = {OP_STUR, imm9, 2'b00, rn, rd};
            K_B:    w = {OP_B, jump};
            // X31 more often so that CBZ is taken now and then
            K_CBZ:  w = {OP_CBZ, jump[18:0], (rand_below(4) == 0) ? 5'd31 : rd};
            K_BLT:  w = {OP_BLT, jump[18:0], 5'b01011};
            default: w = '0;
        endcase
        return w;
    endfunction

    task automatic build_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            kinds[i] = kind_e'(rand_below(12));
            prog[i]  = make_instr(kinds[i]);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "word mismatch on %s", name);
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act) begin
            $display("FAIL %s expected %0d actual %0d", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "index mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAIL %s expected %b actual %b", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "bit mismatch on %s", name);
        end
    endtask

    // present one instruction, check the DUT against the model, advance the model
    task automatic run_instruction();
        instr_t      w;
        kind_e       k;
        string       tag;
        reg_idx_t    rd;
        reg_idx_t    rn;
        reg_idx_t    rm;
        word_t       a;
        word_t       b;
        word_t       res;
        word_t       addr;
        word_t       offset;
        logic [64:0] wide;
        logic        exp_we;
        logic        exp_re;
        logic        exp_wb;
        logic        taken;
        k   = kinds[int'(model_pc >> 2)];
        w   = prog[int'(model_pc >> 2)];
        tag = $sformatf("pc %0h %s", model_pc, k.name());
        check_word({tag, " imem_addr"}, model_pc, imem_addr);
        imem_data = w;
        #1;
        dmem_rdata = mem_read(dmem_addr);
        #1;
        rd     = w[4:0];
        rn     = w[9:5];
        rm     = w[20:16];
        a      = reg_val(rn);
        b      = reg_val(rm);
        res    = '0;
        addr   = a + {{55{w[20]}}, w[20:12]};
        offset = {{43{w[23]}}, w[23:5], 2'b00};
        exp_we = 1'b0;
        exp_re = 1'b0;
        exp_wb = 1'b0;
        taken  = 1'b0;
        case (k)
            K_ADDI: begin
                res    = a + {52'd0, w[21:10]};
                exp_wb = 1'b1;
            end
            K_ADDS, K_SUBS: begin
                // V set when the sign-extended 65-bit result leaves the 64-bit range
                wide    = (k == K_ADDS) ? {a[63], a} + {b[63], b} : {a[63], a} - {b[63], b};
                res     = wide[63:0];
                model_n = res[63];
                model_v = wide[64] ^ wide[63];
                exp_wb  = 1'b1;
            end
            K_AND: begin
                res    = a & b;
                exp_wb = 1'b1;
            end
            K_EOR: begin
                res    = a ^ b;
                exp_wb = 1'b1;
            end
            K_LSR: begin
                res    = a >> w[15:10];
                exp_wb = 1'b1;
            end
            K_LDUR: begin
                res    = mem_read(addr);
                exp_re = 1'b1;
                exp_wb = 1'b1;
            end
            K_STUR: exp_we = 1'b1;
            K_B: begin
                offset = {{36{w[25]}}, w[25:0], 2'b00};
                taken  = 1'b1;
            end
            K_CBZ: taken = (reg_val(rd) == '0);
            K_BLT: taken = (model_n != model_v);
            default: taken = 1'b0;
        endcase
        check_bit({tag, " wb_en"}, exp_wb, wb_en);
        check_bit({tag, " dmem_we"}, exp_we, dmem_we);
        check_bit({tag, " dmem_re"}, exp_re, dmem_re);
        if (exp_wb) begin
            check_idx({tag, " wb_addr"}, rd, wb_addr);
            check_word({tag, " wb_data"}, res, wb_data);
        end
        if (exp_we || exp_re) begin
            check_word({tag, " dmem_addr"}, addr, dmem_addr);
        end
        if (exp_we) begin
            check_word({tag, " dmem_wdata"}, reg_val(rd), dmem_wdata);
            pending_we   = 1'b1;
            pending_addr = addr;
            pending_data = reg_val(rd);
        end
        if (exp_wb && rd != ZERO_REG) begin
            model_regs[rd] = res;
        end
        model_pc = taken ? model_pc + offset : model_pc + 64'd4;
    endtask

    initial begin
        imem_data  = '0;
        dmem_rdata = '0;
        rng        = 64'd85;
        pending_we = 1'b0;
        model_pc   = '0;
        model_n    = 1'b0;
        model_v    = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        build_program();

        // word 0 sits on the fetch port while reset is held
        #1;
        while (rst_n !== 1'b1) begin
            @(negedge clk or posedge rst_n);
            if (rst_n !== 1'b1) begin
                check_bit("reset wb_en", 1'b0, wb_en);
                check_bit("reset dmem_we", 1'b0, dmem_we);
                check_bit("reset dmem_re", 1'b0, dmem_re);
                check_word("reset imem_addr", '0, imem_addr);
            end
        end

        while (model_pc < PROG_END) begin
            run_instruction();
            @(posedge clk);
            // the store commits at the same edge as the register write
            if (pending_we) begin
                dmem[pending_addr] = pending_data;
                pending_we = 1'b0;
            end
            #1;
        end
        // the fetch address of the DUT has to leave the program as well
        check_word("end imem_addr", model_pc, imem_addr);
        $display("TEST OK");
        $finish;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the program did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

endmodule

// ==== list.f ====
src/cpu_pkg.sv
src/decoder.sv
src/imm_gen.sv
src/regfile.sv
src/alu.sv
src/pc_branch.sv
src/cpu_top.sv
sim/tb_clk.sv
sim/cpu_sva.sv
sim/tb_cpu.sv

// ==== Makefile ====
# Verilator build and run for the single-cycle core

VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
# compile output of Verilator
SEED_LOG  ?= build.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for failures"
	@echo "  clean  remove build products and logs"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) \
		> $(SEED_LOG) 2>&1 || (cat $(SEED_LOG); exit 1)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "TEST FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG) $(SEED_LOG)
